/* source/mem_sys_pkg.sv */
package mem_sys_pkg;

   // Geometry of the data memory subsystem
   localparam int word_w         = 16;
   localparam int tag_w          = 5;
   localparam int index_w        = 8;
   localparam int words_per_line = 4;
   // Cycles from memory read strobe to data
   localparam int read_latency   = 2;

   // Derived sizes
   localparam int word_sel_w = $clog2(words_per_line);
   localparam int num_lines  = 2 ** index_w;
   // Each bank row holds one word of one block
   localparam int bank_row_w = tag_w + index_w;
   localparam int bank_rows  = 2 ** bank_row_w;

   // Byte address, seen whole or split into cache fields
   typedef union packed {
      logic [word_w-1:0] raw;
      struct packed {
         logic [tag_w-1:0]      tag;
         logic [index_w-1:0]    index;
         logic [word_sel_w-1:0] word;
         logic                  byte_off;
      } f;
   } mem_addr_t;

   // Controller states, write-back and fill run in code order
   typedef enum logic [3:0] {
      IDLE,
      WB_0, WB_1, WB_2, WB_3,
      RD_0, RD_1, RD_2, RD_3, RD_4, RD_5,
      RETRY
   } ctrl_state_t;

endpackage

/* source/line_cache.sv */
module line_cache
   import mem_sys_pkg::*;
(
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  enable,
   input  logic                  comp,
   input  logic                  write,
   input  logic                  valid_in,
   input  logic [tag_w-1:0]      tag_in,
   input  logic [index_w-1:0]    index,
   input  logic [word_sel_w-1:0] word,
   input  logic [word_w-1:0]     data_in,
   output logic                  hit,
   output logic                  valid,
   output logic                  dirty,
   output logic [tag_w-1:0]      tag_out,
   output logic [word_w-1:0]     data_out
);

   // Line storage
   logic [tag_w-1:0]     tag_mem [num_lines];
   logic [num_lines-1:0] valid_bits;
   logic [num_lines-1:0] dirty_bits;
   logic [word_w-1:0]    data_mem [num_lines][words_per_line];

   logic tag_match;
   logic do_write;

   // Lookup of the addressed line, purely combinational
   assign tag_out   = tag_mem[index];
   assign valid     = valid_bits[index];
   assign dirty     = dirty_bits[index];
   assign data_out  = data_mem[index][word];
   assign tag_match = (tag_out == tag_in);
   assign hit       = enable & comp & tag_match;

   // Compare write only lands on a valid matching line
   // Access write (fill) always lands
   assign do_write = enable & write & (~comp | (tag_match & valid));

   always_ff @(posedge clk) begin
      if (rst) begin
         valid_bits <= '0;
      end else if (do_write && !comp) begin
         valid_bits[index] <= valid_in;
      end
   end

   always_ff @(posedge clk) begin
      if (do_write) begin
         data_mem[index][word] <= data_in;
         // Processor store marks dirty, fill leaves it clean
         dirty_bits[index] <= comp;
         if (!comp) begin
            // New block, take its tag
            tag_mem[index] <= tag_in;
         end
      end
   end

endmodule

/* source/four_bank_mem.sv */
module four_bank_mem
   import mem_sys_pkg::*;
(
   input  logic              clk,
   input  logic              rst,
   input  logic [word_w-1:0] addr,
   input  logic [word_w-1:0] data_in,
   input  logic              rd,
   input  logic              wr,
   output logic [word_w-1:0] data_out
);

   mem_addr_t             a;
   logic [word_sel_w-1:0] bank;
   logic [bank_row_w-1:0] row;

   // Read pipeline, stage 1 carries bank and row
   logic                  s1_valid;
   logic [word_sel_w-1:0] s1_bank;
   logic [bank_row_w-1:0] s1_row;
   // Stage 2 carries the bank that owns the read word
   logic                  s2_valid;
   logic [word_sel_w-1:0] s2_bank;
   logic [word_w-1:0]     bank_q [words_per_line];

   // Word interleave, consecutive words go to consecutive banks
   assign a    = mem_addr_t'(addr);
   assign bank = a.f.word;
   assign row  = {a.f.tag, a.f.index};

   for (genvar b = 0; b < words_per_line; b++) begin : g_bank
      logic [word_w-1:0] mem [bank_rows];

      // Memory powers up cleared
      initial begin
         for (int i = 0; i < bank_rows; i++) begin
            mem[i] = '0;
         end
      end

      always_ff @(posedge clk) begin
         if (wr && bank == b) begin
            mem[row] <= data_in;
         end
         // Second stage, array read for the selected bank only
         if (s1_valid && s1_bank == b) begin
            bank_q[b] <= mem[s1_row];
         end
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         s1_valid <= 1'b0;
         s2_valid <= 1'b0;
      end else begin
         s1_valid <= rd;
         s2_valid <= s1_valid;
      end
   end

   always_ff @(posedge clk) begin
      s1_bank <= bank;
      s1_row  <= row;
      s2_bank <= s1_bank;
   end

   // Zero when no read completes this cycle
   assign data_out = s2_valid ? bank_q[s2_bank] : '0;

endmodule

/* source/cache_ctrl.sv */
module cache_ctrl
   import mem_sys_pkg::*;
(
   input  logic                  clk,
   input  logic                  rst,
   input  logic [word_w-1:0]     addr,
   input  logic [word_w-1:0]     data_in,
   input  logic                  rd,
   input  logic                  wr,
   output logic [word_w-1:0]     data_out,
   output logic                  done,
   output logic                  stall,
   output logic                  cache_hit,
   output logic                  err,
   output logic                  c_enable,
   output logic                  c_comp,
   output logic                  c_write,
   output logic                  c_valid_in,
   output logic [tag_w-1:0]      c_tag_in,
   output logic [index_w-1:0]    c_index,
   output logic [word_sel_w-1:0] c_word,
   output logic [word_w-1:0]     c_data_in,
   input  logic                  c_hit,
   input  logic                  c_valid,
   input  logic                  c_dirty,
   input  logic [tag_w-1:0]      c_tag_out,
   input  logic [word_w-1:0]     c_data_out,
   output logic [word_w-1:0]     mem_addr,
   output logic [word_w-1:0]     mem_data_in,
   output logic                  mem_rd,
   output logic                  mem_wr,
   input  logic [word_w-1:0]     mem_data_out
);

   ctrl_state_t state, next_state;

   mem_addr_t             in_addr, sel_addr;
   // Request held for the whole miss sequence
   mem_addr_t             req_addr;
   logic [word_w-1:0]     req_data;
   logic                  req_wr;

   logic                  req_valid;
   logic                  bad_req;
   logic                  hit_ok;
   logic [3:0]            step;
   logic [word_sel_w-1:0] wb_word;

   assign in_addr   = mem_addr_t'(addr);
   assign req_valid = rd | wr;
   // Odd address or both strobes
   assign bad_req   = in_addr.f.byte_off | (rd & wr);
   assign hit_ok    = c_hit & c_valid;
   // Live address in IDLE, latched one otherwise
   assign sel_addr  = (state == IDLE) ? in_addr : req_addr;
   // Position within the write-back and fill walks
   assign wb_word   = word_sel_w'(state - WB_0);
   assign step      = 4'(state - RD_0);

   always_comb begin
      next_state = state;
      case (state)
         IDLE: begin
            if (req_valid && !bad_req && !hit_ok) begin
               next_state = (c_valid && c_dirty) ? WB_0 : RD_0;
            end
         end
         RETRY:   next_state = IDLE;
         // WB_3 runs into RD_0, RD_5 into RETRY
         default: next_state = ctrl_state_t'(state + 1);
      endcase
   end

   always_comb begin
      c_enable    = 1'b0;
      c_comp      = 1'b0;
      c_write     = 1'b0;
      c_valid_in  = 1'b0;
      c_tag_in    = sel_addr.f.tag;
      c_index     = sel_addr.f.index;
      c_word      = sel_addr.f.word;
      c_data_in   = req_data;
      mem_addr    = '0;
      mem_data_in = '0;
      mem_rd      = 1'b0;
      mem_wr      = 1'b0;
      case (state)
         IDLE: begin
            // Rejected requests never touch the cache
            c_enable  = req_valid & ~bad_req;
            c_comp    = 1'b1;
            c_write   = wr;
            c_data_in = data_in;
         end
         RETRY: begin
            c_enable = 1'b1;
            c_comp   = 1'b1;
            c_write  = req_wr;
         end
         default: begin
            if (state inside {[WB_0:WB_3]}) begin
               // Old block out, address built from the stored tag
               c_enable    = 1'b1;
               c_word      = wb_word;
               mem_wr      = 1'b1;
               mem_addr    = {c_tag_out, req_addr.f.index, wb_word, 1'b0};
               mem_data_in = c_data_out;
            end else begin
               // Issue word reads
               if (step < words_per_line) begin
                  mem_rd   = 1'b1;
                  mem_addr = {req_addr.f.tag, req_addr.f.index,
                              word_sel_w'(step), 1'b0};
               end
               // Install each word read_latency cycles after its issue
               if (step >= read_latency) begin
                  c_enable   = 1'b1;
                  c_write    = 1'b1;
                  c_valid_in = 1'b1;
                  c_word     = word_sel_w'(step - read_latency);
                  c_data_in  = mem_data_out;
               end
            end
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (state == IDLE && req_valid) begin
         req_addr <= in_addr;
         req_data <= data_in;
         req_wr   <= wr;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state     <= IDLE;
         data_out  <= '0;
         done      <= 1'b0;
         stall     <= 1'b0;
         cache_hit <= 1'b0;
         err       <= 1'b0;
      end else begin
         state     <= next_state;
         // Pulses by default
         done      <= 1'b0;
         cache_hit <= 1'b0;
         err       <= 1'b0;
         case (state)
            IDLE: begin
               if (req_valid) begin
                  if (bad_req) begin
                     done <= 1'b1;
                     err  <= 1'b1;
                  end else if (hit_ok) begin
                     done      <= 1'b1;
                     cache_hit <= 1'b1;
                     data_out  <= wr ? data_in : c_data_out;
                  end else begin
                     stall <= 1'b1;
                  end
               end
            end
            RETRY: begin
               // Line now present, hit flag stays low
               done     <= 1'b1;
               stall    <= 1'b0;
               data_out <= req_wr ? req_data : c_data_out;
            end
            default: ;
         endcase
      end
   end

endmodule

/* source/mem_system.sv */
module mem_system
   import mem_sys_pkg::*;
(
   input  logic              clk,
   input  logic              rst,
   input  logic [word_w-1:0] addr,
   input  logic [word_w-1:0] data_in,
   input  logic              rd,
   input  logic              wr,
   output logic [word_w-1:0] data_out,
   output logic              done,
   output logic              stall,
   output logic              cache_hit,
   output logic              err
);

   // Controller to cache
   logic                  c_enable, c_comp, c_write, c_valid_in;
   logic [tag_w-1:0]      c_tag_in;
   logic [index_w-1:0]    c_index;
   logic [word_sel_w-1:0] c_word;
   logic [word_w-1:0]     c_data_in;
   // Cache back to controller
   logic                  c_hit, c_valid, c_dirty;
   logic [tag_w-1:0]      c_tag_out;
   logic [word_w-1:0]     c_data_out;
   // Memory side
   logic [word_w-1:0]     mem_addr, mem_data_in, mem_data_out;
   logic                  mem_rd, mem_wr;

   cache_ctrl ctrl_i (.*);

   line_cache cache_i (
      .clk, .rst,
      .enable(c_enable), .comp(c_comp), .write(c_write), .valid_in(c_valid_in),
      .tag_in(c_tag_in), .index(c_index), .word(c_word), .data_in(c_data_in),
      .hit(c_hit), .valid(c_valid), .dirty(c_dirty),
      .tag_out(c_tag_out), .data_out(c_data_out)
   );

   four_bank_mem mem_i (
      .clk, .rst,
      .addr(mem_addr), .data_in(mem_data_in), .rd(mem_rd), .wr(mem_wr),
      .data_out(mem_data_out)
   );

endmodule

/* sim/mem_system_assertions.sv */
module mem_system_assertions
   import mem_sys_pkg::*;
(
   input logic        clk,
   input logic        rst,
   input logic        done,
   input logic        stall,
   input logic        cache_hit,
   input logic        err,
   input logic        mem_rd,
   input logic        mem_wr,
   input ctrl_state_t state
);

   timeunit 1ns;
   timeprecision 100ps;

   // Read by the testbench top at the end of the run
   int fail_count = 0;

   // done is a single-cycle pulse
   done_pulse: assert property (@(posedge clk) disable iff (rst) done |=> !done)
      else begin
         $error("done high in two consecutive cycles");
         fail_count++;
      end

   // Result flags only come with done
   hit_with_done: assert property (@(posedge clk) disable iff (rst) cache_hit |-> done)
      else begin
         $error("cache_hit high without done");
         fail_count++;
      end

   err_with_done: assert property (@(posedge clk) disable iff (rst) err |-> done)
      else begin
         $error("err high without done");
         fail_count++;
      end

   stall_done_excl: assert property (@(posedge clk) disable iff (rst) !(stall && done))
      else begin
         $error("stall and done high together");
         fail_count++;
      end

   // One memory operation per cycle
   mem_op_excl: assert property (@(posedge clk) disable iff (rst) !(mem_rd && mem_wr))
      else begin
         $error("mem_rd and mem_wr high together");
         fail_count++;
      end

   // Stall tracks any state outside IDLE
   stall_state: assert property (@(posedge clk) disable iff (rst)
                                 stall == (state != IDLE))
      else begin
         $error("stall does not match controller state");
         fail_count++;
      end

endmodule

/* sim/mem_system_checker.sv */
module mem_system_checker
   import mem_sys_pkg::*;
(
   input logic              clk,
   input logic              rst,
   input logic              rd,
   input logic              wr,
   input logic              stall,
   input logic              done,
   input logic              cache_hit,
   input logic              err,
   input logic [word_w-1:0] data_out
);

   timeunit 1ns;
   timeprecision 100ps;

   int checked     = 0;
   int mismatches  = 0;
   int other_fails = 0;

   // Access in flight and its captured result
   logic              busy       = 1'b0;
   int                results    = 0;
   int                taken      = 0;
   int                cycles     = 0;
   logic [word_w-1:0] got_data   = '0;
   logic              got_hit    = 1'b0;
   logic              got_err    = 1'b0;
   int                got_cycles = 0;

   // Sample at the falling edge where outputs are settled
   always @(negedge clk) begin
      if (rst) begin
         busy <= 1'b0;
      end else if (!busy) begin
         // Cycle 0 of a new access
         if ((rd || wr) && !stall) begin
            busy   <= 1'b1;
            cycles <= 0;
         end
      end else begin
         cycles <= cycles + 1;
         if (done) begin
            busy       <= 1'b0;
            results    <= results + 1;
            got_data   <= data_out;
            got_hit    <= cache_hit;
            got_err    <= err;
            got_cycles <= cycles + 1;
         end
      end
   end

   task automatic check_value(input string where, input string name,
                              input logic [word_w-1:0] got, input logic [word_w-1:0] want);
      if (got !== want) begin
         mismatches++;
         $display("FAILED %s: %s got 0x%h expected 0x%h", where, name, got, want);
      end
   endtask

   // Failure that belongs to no single signal
   task automatic report_problem(input string what);
      other_fails++;
      $display("ERROR: %s", what);
   endtask

   // Outputs right after reset
   task automatic check_idle();
      check_value("after reset", "data_out", data_out, '0);
      check_value("after reset", "done", word_w'(done), '0);
      check_value("after reset", "stall", word_w'(stall), '0);
      check_value("after reset", "cache_hit", word_w'(cache_hit), '0);
      check_value("after reset", "err", word_w'(err), '0);
   endtask

   task automatic compare_result(input int idx, input logic [word_w-1:0] exp_data,
                                 input logic exp_hit, input logic exp_err,
                                 input int exp_cycles);
      string where;
      where = $sformatf("pattern %0d", idx);
      checked++;
      // Each access must leave exactly one new result behind
      if (results != taken + 1) begin
         report_problem($sformatf("%s left %0d captured results instead of one",
                                  where, results - taken));
      end else begin
         check_value(where, "data_out", got_data, exp_data);
         check_value(where, "cache_hit", word_w'(got_hit), word_w'(exp_hit));
         check_value(where, "err", word_w'(got_err), word_w'(exp_err));
         check_value(where, "latency", word_w'(got_cycles), word_w'(exp_cycles));
      end
      taken = results;
   endtask

   function automatic int total_errors();
      return mismatches + other_fails;
   endfunction

   task automatic print_summary(input int assert_fails);
      $display("Summary: %0d checked, %0d mismatches, %0d other failures, %0d assertion failures",
               checked, mismatches, other_fails, assert_fails);
   endtask

endmodule

/* sim/mem_system_tb.sv */
module mem_system_tb
   import mem_sys_pkg::*;
();

   timeunit 1ns;
   timeprecision 100ps;

   logic              clk;
   logic              rst;
   logic [word_w-1:0] addr;
   logic [word_w-1:0] data_in;
   logic              rd;
   logic              wr;
   logic [word_w-1:0] data_out;
   logic              done;
   logic              stall;
   logic              cache_hit;
   logic              err;

   mem_system mem_system_i (.*);

   mem_system_checker chk_i (
      .clk, .rst, .rd, .wr, .stall, .done, .cache_hit, .err, .data_out
   );

   // Protocol checks live inside the DUT scope
   bind mem_system mem_system_assertions asrt_i (
      .clk, .rst, .done, .stall, .cache_hit, .err, .mem_rd, .mem_wr,
      .state(ctrl_i.state)
   );

   // 8 ns period
   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   // One-cycle strobe, then wait for done
   // Entered and left just after a rising edge
   task automatic run_access(input byte op, input logic [word_w-1:0] a,
                             input logic [word_w-1:0] wd, output logic timed_out);
      int waited;
      addr    <= a;
      data_in <= wd;
      rd      <= (op == "R" || op == "X");
      wr      <= (op == "W" || op == "X");
      @(posedge clk);
      rd <= 1'b0;
      wr <= 1'b0;
      waited    = 0;
      timed_out = 1'b1;
      // Longest access is 12 cycles
      while (waited < 50) begin
         @(negedge clk);
         if (done) begin
            timed_out = 1'b0;
            break;
         end
         waited++;
      end
      @(posedge clk);
   endtask

   initial begin
      string             line;
      byte               op;
      logic [word_w-1:0] p_addr;
      logic [word_w-1:0] p_wdata;
      logic [word_w-1:0] p_data;
      int                p_hit;
      int                p_err;
      int                p_cycles;
      int                fd;
      int                fields;
      int                idx;
      int                asrt_fails;
      logic              timed_out;

      addr      = '0;
      data_in   = '0;
      rd        = 1'b0;
      wr        = 1'b0;
      rst       = 1'b1;
      idx       = 0;
      timed_out = 1'b0;
      repeat (4) @(posedge clk);
      rst <= 1'b0;
      @(negedge clk);
      chk_i.check_idle();
      @(posedge clk);

      fd = $fopen("sim/mem_system_patterns.txt", "r");
      if (fd == 0) begin
         chk_i.report_problem("cannot open sim/mem_system_patterns.txt");
      end else begin
         while (!timed_out && $fgets(line, fd) > 0) begin
            // Skip column notes and blank lines
            if (line.len() < 2 || line[0] == "#") begin
               continue;
            end
            fields = $sscanf(line, "%c %h %h %h %d %d %d", op, p_addr, p_wdata, p_data,
                             p_hit, p_err, p_cycles);
            if (fields != 7 || !(op inside {"R", "W", "X"})) begin
               chk_i.report_problem($sformatf("unreadable pattern line: %s", line));
               continue;
            end
            idx++;
            run_access(op, p_addr, p_wdata, timed_out);
            if (timed_out) begin
               chk_i.report_problem($sformatf("pattern %0d got no done within 50 cycles",
                                              idx));
            end else begin
               chk_i.compare_result(idx, p_data, p_hit[0], p_err[0], p_cycles);
            end
         end
         $fclose(fd);
         if (idx == 0) begin
            chk_i.report_problem("pattern file held no accesses");
         end
      end

      asrt_fails = mem_system_i.asrt_i.fail_count;
      chk_i.print_summary(asrt_fails);
      if (chk_i.total_errors() + asrt_fails == 0) begin
         $display("TEST PASSED");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

/* filelist.f */
source/mem_sys_pkg.sv
source/line_cache.sv
source/four_bank_mem.sv
source/cache_ctrl.sv
source/mem_system.sv
sim/mem_system_assertions.sv
sim/mem_system_checker.sv
sim/mem_system_tb.sv

/* sim/mem_system_patterns.txt */
# Columns op addr wdata exp_data exp_hit exp_err exp_cycles
# op is R, W or X (both strobes), words in hex, flags and cycles in decimal
R 0880 0000 0000 0 0 8
W 0880 1234 1234 1 0 1
R 0880 0000 1234 1 0 1
R 0882 0000 0000 1 0 1
R 0884 0000 0000 1 0 1
W 0886 beef beef 1 0 1
R 1080 0000 0000 0 0 12
R 0886 0000 beef 0 0 8
R 0880 0000 1234 1 0 1
R 1080 0000 0000 0 0 8
W 1882 5a5a 5a5a 0 0 8
X 1882 0000 5a5a 0 1 1
R 1883 0000 5a5a 0 1 1
R 1882 0000 5a5a 1 0 1
R 0880 0000 1234 0 0 12
R 1882 0000 5a5a 0 0 8
